/* test/cacheVectors.txt */
# address(hex) hit hold gaps name
# hit is the expected hit flag, hold keeps valid_i high into the next line, gaps uses random beat gaps
00000868 0 0 0 coldMiss
00000860 1 0 0 sameLineHit
00000870 1 0 0 sameLineHit
0000087c 1 0 0 sameLineHit
00001060 0 0 0 secondWayFill
00000860 1 0 0 twoWayHit
00001068 1 0 0 twoWayHit
00000870 1 0 0 twoWayHit
00001078 1 0 0 twoWayHit
00001860 0 0 0 lruEvict
00001070 1 0 0 lruKeep
00000868 0 0 0 evictedMiss
00001060 1 0 0 lruKeep
00001868 0 0 0 evictedMiss
00001870 1 0 0 lruKeep
00000860 0 0 0 lruEvict
00001868 1 0 0 lruKeep
00001060 0 0 0 evictedMiss
000020a0 0 0 0 backToBackFill
000020a8 1 1 0 backToBack
000020b0 1 1 0 backToBack
000020b8 1 1 0 backToBack
00001868 1 1 0 backToBack
00001060 1 1 0 backToBack
000020a4 1 0 0 backToBack
deadbee8 0 1 1 gapRefill
deadbee0 1 1 1 gapHit
deadbef8 1 0 1 gapHit
fffffff8 0 0 1 gapRefill
ffffffe0 1 0 1 gapHit
12345674 0 0 1 gapRefill
1234567c 1 1 1 gapHit
12345660 1 0 1 gapHit
000006f0 0 0 1 gapRefill
deadbef0 1 0 0 gapHit
000006e8 1 0 0 gapHit
00000860 0 0 1 gapEvict
00001864 0 0 1 gapEvict
00000870 1 0 0 gapHit
0000106c 0 0 0 gapEvict

/* sim.f */
source/cachePkg.sv
source/dataSram.sv
source/refillBuffer.sv
source/tagStore.sv
source/cacheCtrl.sv
source/cacheTop.sv
test/cacheTb.sv

/* test/cacheTb.sv */
module cacheTb import cachePkg::*; ();

  localparam int ACCEPT_LIMIT = 100;
  localparam int DRAIN_LIMIT  = 100;
  localparam int IDLE_LIMIT   = 5000;
  localparam int DROP_LIMIT   = 10;
  localparam int HIT_LATENCY  = 2;

  logic     clk;
  logic     rst_n;
  logic     valid;
  addr_t    addr;
  logic     addrOk;
  logic     dataOk;
  word_t    rdData;
  logic     memRdReq;
  addr_t    memAddr;
  memBeat_t memBeat;

  // vectors as read from the file
  addr_t vecAddr[$];
  logic  vecHit[$];
  bit    vecHold[$];
  bit    vecGaps[$];
  string vecName[$];

  // accepted requests waiting for dataOk_o
  addr_t pendAddr[$];
  logic  pendHit[$];
  bit    pendGaps[$];
  string pendName[$];
  int    pendCycle[$];

  int     errors = 0;
  int     checks = 0;
  int     cycle = 0;
  bit     aborted = 1'b0;
  bit     missSeen = 1'b0;
  integer seed = 32'h20d4_294a;

  cacheTop u_cacheTop (
    .clk        (clk),
    .rst_n      (rst_n),
    .valid_i    (valid),
    .addr_i     (addr),
    .addrOk_o   (addrOk),
    .dataOk_o   (dataOk),
    .rdData_o   (rdData),
    .memRdReq_o (memRdReq),
    .memAddr_o  (memAddr),
    .memBeat_i  (memBeat)
  );

  // memory word is the inverted address above the address itself
  function automatic word_t memWord(input addr_t a);
    return {~a, a};
  endfunction

  task automatic checkData(input string name, input word_t expVal, input word_t actVal);
    checks++;
    if (actVal !== expVal) begin
      errors++;
      $display("Fail %s: data expected %h, actual %h", name, expVal, actVal);
    end
  endtask

  task automatic checkRefillAddr(input string name, input addr_t expVal, input addr_t actVal);
    checks++;
    if (actVal !== expVal) begin
      errors++;
      $display("Fail %s: refill address expected %h, actual %h", name, expVal, actVal);
    end
  endtask

  task automatic checkHit(input string name, input logic expVal, input logic actVal);
    checks++;
    if (actVal !== expVal) begin
      errors++;
      $display("Fail %s: hit expected %b, actual %b", name, expVal, actVal);
    end
  endtask

  task automatic checkLatency(input string name, input int expVal, input int actVal);
    checks++;
    if (actVal != expVal) begin
      errors++;
      $display("Fail %s: hit latency expected %0d, actual %0d", name, expVal, actVal);
    end
  endtask

  task automatic checkAcceptDelay(input string name, input int expVal, input int actVal);
    checks++;
    if (actVal != expVal) begin
      errors++;
      $display("Fail %s: accept delay expected %0d, actual %0d", name, expVal, actVal);
    end
  endtask

  task automatic abortRun(input string what);
    errors++;
    aborted = 1'b1;
    $display("%s", what);
  endtask

  task automatic finishRun();
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  endtask

  task automatic loadVectors();
    int    fd;
    int    n;
    string line;
    addr_t a;
    int    h;
    int    hd;
    int    g;
    string nm;
    fd = $fopen("test/cacheVectors.txt", "r");
    if (fd == 0) begin
      abortRun("cannot open test/cacheVectors.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        // skip comment lines
        if (n > 0 && line.getc(0) != "#") begin
          n = $sscanf(line, "%h %d %d %d %s", a, h, hd, g, nm);
          if (n == 5) begin
            vecAddr.push_back(a);
            vecHit.push_back(h != 0);
            vecHold.push_back(hd != 0);
            vecGaps.push_back(g != 0);
            vecName.push_back(nm);
          end
        end
      end
      $fclose(fd);
      if (vecAddr.size() == 0) begin
        abortRun("no vectors found in test/cacheVectors.txt");
      end
    end
  endtask

  // waits for addrOk_o at falling edges and queues the request
  task automatic waitAccept(input int idx);
    int n;
    n = 0;
    @(negedge clk);
    while (addrOk !== 1'b1 && !aborted && n < ACCEPT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (addrOk === 1'b1 && !aborted) begin
      pendAddr.push_back(vecAddr[idx]);
      pendHit.push_back(vecHit[idx]);
      pendGaps.push_back(vecGaps[idx]);
      pendName.push_back(vecName[idx]);
      pendCycle.push_back(cycle);
      // a request held behind a hit is taken in the very next cycle
      if (idx > 0 && vecHold[idx-1] && vecHit[idx-1]) begin
        checkAcceptDelay(vecName[idx], 0, n);
      end
    end else if (!aborted) begin
      abortRun($sformatf("timed out waiting for addrOk_o on %s", vecName[idx]));
    end
  endtask

  task automatic waitDrain(input string name);
    int n;
    n = 0;
    while (pendAddr.size() != 0 && !aborted && n < DRAIN_LIMIT) begin
      @(posedge clk);
      n++;
    end
    if (pendAddr.size() != 0 && !aborted) begin
      abortRun($sformatf("timed out waiting for dataOk_o after %s", name));
    end
  endtask

  task automatic runVectors();
    int i;
    i = 0;
    @(posedge clk);
    while (i < vecAddr.size() && !aborted) begin
      valid <= 1'b1;
      addr  <= vecAddr[i];
      waitAccept(i);
      if (!aborted) begin
        // the next request or idle follows the accepting edge
        @(posedge clk);
        if (!vecHold[i] || i == vecAddr.size() - 1) begin
          valid <= 1'b0;
          waitDrain(vecName[i]);
        end
      end
      i++;
    end
  endtask

  task automatic takeResponse();
    addr_t a;
    string name;
    logic  expHit;
    logic  actHit;
    int    okCycle;
    if (pendAddr.size() == 0) begin
      errors++;
      $display("dataOk_o pulsed with no request outstanding");
    end else begin
      a       = pendAddr.pop_front();
      name    = pendName.pop_front();
      expHit  = pendHit.pop_front();
      okCycle = pendCycle.pop_front();
      pendGaps.delete(0);
      actHit  = !missSeen;
      missSeen = 1'b0;
      checkHit(name, expHit, actHit);
      checkData(name, memWord({a[ADDR_W-1:3], 3'b000}), rdData);
      if (actHit) begin
        checkLatency(name, HIT_LATENCY, cycle - okCycle);
      end
    end
  endtask

  task automatic serveRefill();
    addr_t    lineAddr;
    bit       useGaps;
    int       gap;
    int       b;
    int       n;
    memBeat_t beat;
    useGaps = 1'b0;
    if (pendAddr.size() == 0) begin
      errors++;
      $display("memRdReq_o raised with no request outstanding");
    end else begin
      checkRefillAddr(pendName[0], {pendAddr[0][ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}}, memAddr);
      useGaps = pendGaps[0];
    end
    missSeen = 1'b1;
    lineAddr = memAddr;
    for (b = 0; b < BEATS; b++) begin
      gap = useGaps ? ($unsigned($random(seed)) % 4) : 0;
      repeat (gap) begin
        @(posedge clk);
        memBeat <= '0;
      end
      beat.valid = 1'b1;
      beat.last  = (b == BEATS - 1);
      beat.data  = memWord(lineAddr + addr_t'(b * (XLEN / 8)));
      @(posedge clk);
      memBeat <= beat;
    end
    @(posedge clk);
    memBeat <= '0;
    n = 0;
    @(negedge clk);
    while (memRdReq === 1'b1 && n < DROP_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (memRdReq === 1'b1) begin
      abortRun("memRdReq_o stayed high after the last beat");
    end
  endtask

  initial begin : clockGen
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  initial begin : responseMonitor
    forever begin
      @(negedge clk);
      if (rst_n === 1'b1 && dataOk === 1'b1) begin
        takeResponse();
      end
    end
  end

  // answers each line request with four beats
  initial begin : memResponder
    int n;
    while (!aborted) begin
      n = 0;
      @(negedge clk);
      while (memRdReq !== 1'b1 && !aborted && n < IDLE_LIMIT) begin
        @(negedge clk);
        n++;
      end
      if (!aborted && memRdReq !== 1'b1) begin
        abortRun($sformatf("no memory read request seen in %0d cycles", IDLE_LIMIT));
      end else if (!aborted) begin
        serveRefill();
      end
    end
  end

  initial begin : mainFlow
    rst_n   = 1'b0;
    valid   = 1'b0;
    addr    = '0;
    memBeat = '0;
    loadVectors();
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    runVectors();
    finishRun();
  end

endmodule

/* source/cacheTop.sv */
module cacheTop import cachePkg::*; #(
  parameter int DEPTH = NUM_SETS,
  parameter int WIDTH = LINE_W / 2
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     valid_i,
  input  addr_t    addr_i,
  output logic     addrOk_o,
  output logic     dataOk_o,
  output word_t    rdData_o,
  output logic     memRdReq_o,
  output addr_t    memAddr_o,
  input  memBeat_t memBeat_i
);

  logic               sramEn;
  logic [INDEX_W-1:0] sramIndex;
  logic [1:0]         sramWe;
  logic               lookupEn;
  lookup_t            lookup;
  logic               fillEn;
  logic               fillWay;
  reqFields_t         reqFields;
  logic               lineDone;
  line_t              refillLine;
  // [way][half], half 0 holds the low words of the line
  logic [WIDTH-1:0]   halfData [2][2];

  cacheCtrl u_cacheCtrl (
    .clk,
    .rst_n,
    .valid_i,
    .addr_i,
    .addrOk_o,
    .dataOk_o,
    .rdData_o,
    .memRdReq_o,
    .memAddr_o,
    .sramEn_o     (sramEn),
    .sramIndex_o  (sramIndex),
    .sramWe_o     (sramWe),
    .way0Line_i   ({halfData[0][1], halfData[0][0]}),
    .way1Line_i   ({halfData[1][1], halfData[1][0]}),
    .lookupEn_o   (lookupEn),
    .lookup_i     (lookup),
    .fillEn_o     (fillEn),
    .fillWay_o    (fillWay),
    .reqFields_o  (reqFields),
    .lineDone_i   (lineDone),
    .refillLine_i (refillLine)
  );

  tagStore u_tagStore (
    .clk,
    .rst_n,
    .lookupEn_i    (lookupEn),
    .lookupIndex_i (sramIndex),
    .req_i         (reqFields),
    .fillEn_i      (fillEn),
    .fillWay_i     (fillWay),
    .lookup_o      (lookup)
  );

  refillBuffer u_refillBuffer (
    .clk,
    .rst_n,
    .beat_i     (memBeat_i),
    .line_o     (refillLine),
    .lineDone_o (lineDone)
  );

  // two ways, each split into a low and a high half
  for (genvar w = 0; w < 2; w++) begin : gWay
    for (genvar h = 0; h < 2; h++) begin : gHalf
      dataSram #(
        .DEPTH (DEPTH),
        .WIDTH (WIDTH)
      ) u_dataSram (
        .clk,
        .en_i    (sramEn),
        .we_i    (sramWe[w]),
        .addr_i  (sramIndex),
        .wdata_i (refillLine[h*WIDTH +: WIDTH]),
        .rdata_o (halfData[w][h])
      );
    end
  end

endmodule

/* source/cacheCtrl.sv */
module cacheCtrl import cachePkg::*; (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               valid_i,
  input  addr_t              addr_i,
  output logic               addrOk_o,
  output logic               dataOk_o,
  output word_t              rdData_o,
  output logic               memRdReq_o,
  output addr_t              memAddr_o,
  output logic               sramEn_o,
  output logic [INDEX_W-1:0] sramIndex_o,
  output logic [1:0]         sramWe_o,
  input  line_t              way0Line_i,
  input  line_t              way1Line_i,
  output logic               lookupEn_o,
  input  lookup_t            lookup_i,
  output logic               fillEn_o,
  output logic               fillWay_o,
  output reqFields_t         reqFields_o,
  input  logic               lineDone_i,
  input  line_t              refillLine_i
);

  cacheState_e state;
  cacheState_e nextState;
  reqFields_t  addrFields;
  reqFields_t  reqQ;
  logic        accept;
  logic        lookupHit;
  logic        fill;
  logic        victimQ;
  logic [1:0]  wordSel;
  line_t       hitLine;
  word_t       rdDataQ;
  logic        dataOkQ;

  assign addrFields = reqFields_t'(addr_i);
  assign lookupHit  = (state == LOOKUP) && lookup_i.hit;
  assign fill       = (state == FILL);

  // a new request may enter while idle or behind a hit
  assign accept   = valid_i && ((state == IDLE) || lookupHit);
  assign addrOk_o = accept;

  always_comb begin
    nextState = state;
    unique case (state)
      IDLE:   if (valid_i) nextState = LOOKUP;
      LOOKUP: begin
        if (!lookup_i.hit) begin
          nextState = REFILL;
        end else if (!valid_i) begin
          nextState = IDLE;
        end
      end
      REFILL: if (lineDone_i) nextState = FILL;
      FILL:   nextState = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= IDLE;
    end else begin
      state <= nextState;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      reqQ <= addrFields;
    end
  end

  // remember the victim once the miss is known
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      victimQ <= 1'b0;
    end else if ((state == LOOKUP) && !lookup_i.hit) begin
      victimQ <= lookup_i.victimWay;
    end
  end

  // tag read and data read start together
  assign lookupEn_o  = accept;
  assign sramEn_o    = accept || fill;
  assign sramIndex_o = fill ? reqQ.index : addrFields.index;
  assign sramWe_o    = {victimQ, ~victimQ} & {2{fill}};
  assign fillEn_o    = fill;
  assign fillWay_o   = victimQ;
  assign reqFields_o = reqQ;

  assign memRdReq_o = (state == REFILL);
  assign memAddr_o  = {reqQ.tag, reqQ.index, {OFFSET_W{1'b0}}};

  // word within the line
  assign wordSel = reqQ.offset[OFFSET_W-1:3];
  assign hitLine = lookup_i.hitWay ? way1Line_i : way0Line_i;

  always_ff @(posedge clk) begin
    if (lookupHit) begin
      rdDataQ <= hitLine[wordSel*XLEN +: XLEN];
    end else if (fill) begin
      rdDataQ <= refillLine_i[wordSel*XLEN +: XLEN];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dataOkQ <= 1'b0;
    end else begin
      dataOkQ <= lookupHit || fill;
    end
  end

  assign rdData_o = rdDataQ;
  assign dataOk_o = dataOkQ;

  // no new request while the line is being brought in
  assert property (@(posedge clk) disable iff (!rst_n)
    (state inside {REFILL, FILL}) |-> !addrOk_o);

  assert property (@(posedge clk) disable iff (!rst_n)
    memRdReq_o ##1 memRdReq_o |-> $stable(memAddr_o));

endmodule

/* source/tagStore.sv */
module tagStore import cachePkg::*; (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               lookupEn_i,
  input  logic [INDEX_W-1:0] lookupIndex_i,
  input  reqFields_t         req_i,
  input  logic               fillEn_i,
  input  logic               fillWay_i,
  output lookup_t            lookup_o
);

  logic [TAG_W-1:0]                tagMem [2][NUM_SETS];
  logic [1:0][NUM_SETS-1:0]        validQ;
  // way to replace next, per set
  logic [NUM_SETS-1:0]             lruQ;
  logic [TAG_W-1:0]                tagRd [2];
  logic [1:0]                      validRd;
  logic                            lookupQ;
  logic [1:0]                      wayHit;

  always_ff @(posedge clk) begin
    if (lookupEn_i) begin
      tagRd[0] <= tagMem[0][lookupIndex_i];
      tagRd[1] <= tagMem[1][lookupIndex_i];
    end
    if (fillEn_i) begin
      tagMem[fillWay_i][req_i.index] <= req_i.tag;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validRd <= '0;
      lookupQ <= 1'b0;
    end else begin
      lookupQ <= lookupEn_i;
      if (lookupEn_i) begin
        validRd <= {validQ[1][lookupIndex_i], validQ[0][lookupIndex_i]};
      end
    end
  end

  // compare against the request latched by the controller
  assign wayHit[0] = validRd[0] && (tagRd[0] == req_i.tag);
  assign wayHit[1] = validRd[1] && (tagRd[1] == req_i.tag);

  always_comb begin
    lookup_o.hit    = lookupQ && (wayHit != 2'b00);
    lookup_o.hitWay = wayHit[1];
    // an empty way is filled first
    if (!validRd[0]) begin
      lookup_o.victimWay = 1'b0;
    end else if (!validRd[1]) begin
      lookup_o.victimWay = 1'b1;
    end else begin
      lookup_o.victimWay = lruQ[req_i.index];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validQ <= '0;
      lruQ   <= '0;
    end else if (fillEn_i) begin
      validQ[fillWay_i][req_i.index] <= 1'b1;
      lruQ[req_i.index]              <= ~fillWay_i;
    end else if (lookup_o.hit) begin
      lruQ[req_i.index] <= ~lookup_o.hitWay;
    end
  end

  // a fill never leaves the same tag in both ways
  assert property (@(posedge clk) disable iff (!rst_n)
    lookupQ |-> !(wayHit[0] && wayHit[1]));

endmodule

/* source/refillBuffer.sv */
module refillBuffer import cachePkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  memBeat_t beat_i,
  output line_t    line_o,
  output logic     lineDone_o
);

  logic [$clog2(BEATS)-1:0] beatCnt;
  line_t                    lineQ;

  // lowest word arrives first
  always_ff @(posedge clk) begin
    if (beat_i.valid) begin
      lineQ[beatCnt*XLEN +: XLEN] <= beat_i.data;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beatCnt <= '0;
    end else if (beat_i.valid) begin
      beatCnt <= beat_i.last ? '0 : beatCnt + 1'b1;
    end
  end

  assign line_o = lineQ;
  // line is complete in line_o from the next cycle on
  assign lineDone_o = beat_i.valid && beat_i.last;

  assert property (@(posedge clk) disable iff (!rst_n)
    beat_i.valid |-> (beat_i.last == (beatCnt == BEATS - 1)));

endmodule

/* source/dataSram.sv */
module dataSram #(
  parameter int DEPTH = 64,
  parameter int WIDTH = 128
) (
  input  logic                     clk,
  input  logic                     en_i,
  input  logic                     we_i,
  input  logic [$clog2(DEPTH)-1:0] addr_i,
  input  logic [WIDTH-1:0]         wdata_i,
  output logic [WIDTH-1:0]         rdata_o
);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [WIDTH-1:0] rdataQ;

  // read data holds its value during a write
  always_ff @(posedge clk) begin
    if (en_i) begin
      if (we_i) begin
        mem[addr_i] <= wdata_i;
      end else begin
        rdataQ <= mem[addr_i];
      end
    end
  end

  assign rdata_o = rdataQ;

endmodule

/* source/cachePkg.sv */
package cachePkg;

  // address and data widths
  parameter int ADDR_W   = 32;
  parameter int XLEN     = 64;

  // address split: tag | index | offset
  parameter int OFFSET_W = 5;
  parameter int INDEX_W  = 6;
  parameter int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;

  parameter int NUM_SETS = 1 << INDEX_W;
  parameter int BEATS    = 4;
  parameter int LINE_W   = BEATS * XLEN;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [XLEN-1:0]   word_t;
  typedef logic [LINE_W-1:0] line_t;

  // one address viewed as its fields
  typedef struct packed {
    logic [TAG_W-1:0]    tag;
    logic [INDEX_W-1:0]  index;
    logic [OFFSET_W-1:0] offset;
  } reqFields_t;

  // one beat from the memory port
  typedef struct packed {
    logic  valid;
    logic  last;
    word_t data;
  } memBeat_t;

  // tag store answer, valid in LOOKUP
  typedef struct packed {
    logic hit;
    logic hitWay;
    logic victimWay;
  } lookup_t;

  typedef enum logic [1:0] {
    IDLE,
    LOOKUP,
    REFILL,
    FILL
  } cacheState_e;

endpackage
